/* tb.f */
source/owt_pkg.sv
source/hv_map_pkg.sv
source/owt_frame_if.sv
source/owt_frame_decode.sv
source/hv_shadow_bank.sv
source/hv_fwd_ctrl.sv
source/lv_hv_shadow_top.sv
verif/tb_clk_gen.sv
verif/tb_lv_hv_shadow.sv

/* verif/tb_lv_hv_shadow.sv */
// tb_lv_hv_shadow, stimulus, reference model, output comparison and reporting
`timescale 1ns/1ps
`default_nettype none

module tb_lv_hv_shadow import owt_pkg::*, hv_map_pkg::*; ();

    localparam owt_addr_t ANG_START   = 7'h20;
    localparam owt_addr_t ANG_END     = 7'h3F;
    localparam int        DRIVE_DLY   = 2;
    localparam int        RST_TIMEOUT = 100;
    localparam owt_addr_t SHADOW_ADDR [9] = '{
        ADDR_EFUSE_CONFIG, ADDR_EFUSE_STATUS, ADDR_STATUS1, ADDR_STATUS2, ADDR_STATUS3,
        ADDR_STATUS4, ADDR_BIST1, ADDR_BIST2, ADDR_ADC_DATA
    };

    // expected state of the design after each edge
    typedef struct packed {
        hv_reg_t [7:0] regs;
        hv_adc_t       adc1;
        hv_adc_t       adc2;
        logic          ang_vld;
        hv_reg_t       ang_data;
        logic          dgt_d1;
        logic          dgt_vld;
    } model_t;

    logic clk;
    logic rst_n;
    logic owt_rx_ack;
    logic [OWT_CMD_W-1:0] owt_rx_cmd;
    owt_data_t owt_rx_data;
    logic owt_rx_status;
    logic cur_is_spi_req;
    hv_reg_t reg_efuse_config;
    hv_reg_t reg_efuse_status;
    hv_reg_t reg_status1;
    hv_reg_t reg_status2;
    hv_reg_t reg_status3;
    hv_reg_t reg_status4;
    hv_reg_t reg_bist1;
    hv_reg_t reg_bist2;
    hv_adc_t reg_adc1_data;
    hv_adc_t reg_adc2_data;
    logic hv_ang_reg_vld;
    hv_reg_t hv_ang_reg_data;
    logic hv_dgt_reg_vld;

    model_t model;
    integer seed;
    int err_count;
    int check_count;
    int test_err_base;
    int test_count;
    int fail_count;

    tb_clk_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    lv_hv_shadow_top #(
        .ANG_START_ADDR (ANG_START),
        .ANG_END_ADDR   (ANG_END)
    ) i_dut (
        .i_clk              (clk),
        .i_rst_n            (rst_n),
        .i_owt_rx_ack       (owt_rx_ack),
        .i_owt_rx_cmd       (owt_rx_cmd),
        .i_owt_rx_data      (owt_rx_data),
        .i_owt_rx_status    (owt_rx_status),
        .i_cur_is_spi_req   (cur_is_spi_req),
        .o_reg_efuse_config (reg_efuse_config),
        .o_reg_efuse_status (reg_efuse_status),
        .o_reg_status1      (reg_status1),
        .o_reg_status2      (reg_status2),
        .o_reg_status3      (reg_status3),
        .o_reg_status4      (reg_status4),
        .o_reg_bist1        (reg_bist1),
        .o_reg_bist2        (reg_bist2),
        .o_reg_adc1_data    (reg_adc1_data),
        .o_reg_adc2_data    (reg_adc2_data),
        .o_hv_ang_reg_vld   (hv_ang_reg_vld),
        .o_hv_ang_reg_data  (hv_ang_reg_data),
        .o_hv_dgt_reg_vld   (hv_dgt_reg_vld)
    );

    // ======================================================================
    // reference model
    // ======================================================================

    function automatic logic on_digital_list(owt_addr_t addr);
        case (addr)
            7'h40, 7'h41, 7'h48, 7'h50: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic model_t predict(model_t cur, logic f_ack, logic [OWT_CMD_W-1:0] f_cmd,
                                       owt_data_t f_data, logic f_status, logic f_spi);
        model_t    nxt;
        logic      good;
        owt_addr_t addr;
        nxt  = cur;
        good = f_ack && !f_status;
        addr = f_cmd[OWT_ADDR_W-1:0];
        if (good && !f_cmd[OWT_CMD_W-1]) begin
            case (addr)
                ADDR_EFUSE_CONFIG: nxt.regs[0] = f_data[7:0];
                ADDR_EFUSE_STATUS: nxt.regs[1] = f_data[7:0];
                ADDR_STATUS1:      nxt.regs[2] = f_data[7:0];
                ADDR_STATUS2:      nxt.regs[3] = f_data[7:0];
                ADDR_STATUS3:      nxt.regs[4] = f_data[7:0];
                ADDR_STATUS4:      nxt.regs[5] = f_data[7:0];
                ADDR_BIST1:        nxt.regs[6] = f_data[7:0];
                ADDR_BIST2:        nxt.regs[7] = f_data[7:0];
                ADDR_ADC_DATA: begin
                    nxt.adc1 = f_data[9:0];
                    nxt.adc2 = f_data[19:10];
                end
                default: ;
            endcase
        end
        // forwarding does not care about the read/write flag
        nxt.ang_vld = good && f_spi && (addr >= ANG_START) && (addr <= ANG_END);
        if (nxt.ang_vld) begin
            nxt.ang_data = f_data[7:0];
        end
        nxt.dgt_vld = cur.dgt_d1;
        nxt.dgt_d1  = good && f_spi && on_digital_list(addr);
        return nxt;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model <= '0;
        end else begin
            model <= predict(model, owt_rx_ack, owt_rx_cmd, owt_rx_data, owt_rx_status,
                             cur_is_spi_req);
        end
    end

    // ======================================================================
    // comparison at mid-cycle
    // ======================================================================

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: time %0t ns, %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            compare_value("o_reg_efuse_config", reg_efuse_config, model.regs[0]);
            compare_value("o_reg_efuse_status", reg_efuse_status, model.regs[1]);
            compare_value("o_reg_status1", reg_status1, model.regs[2]);
            compare_value("o_reg_status2", reg_status2, model.regs[3]);
            compare_value("o_reg_status3", reg_status3, model.regs[4]);
            compare_value("o_reg_status4", reg_status4, model.regs[5]);
            compare_value("o_reg_bist1", reg_bist1, model.regs[6]);
            compare_value("o_reg_bist2", reg_bist2, model.regs[7]);
            compare_value("o_reg_adc1_data", reg_adc1_data, model.adc1);
            compare_value("o_reg_adc2_data", reg_adc2_data, model.adc2);
            compare_value("o_hv_ang_reg_vld", hv_ang_reg_vld, model.ang_vld);
            compare_value("o_hv_ang_reg_data", hv_ang_reg_data, model.ang_data);
            compare_value("o_hv_dgt_reg_vld", hv_dgt_reg_vld, model.dgt_vld);
        end
    end

    // ======================================================================
    // stimulus helpers
    // ======================================================================

    function automatic owt_data_t rand_payload();
        return owt_data_t'($random(seed));
    endfunction

    task automatic drive_frame(logic [OWT_CMD_W-1:0] f_cmd, owt_data_t f_data,
                               logic f_status, logic f_spi);
        @(posedge clk);
        #(DRIVE_DLY);
        owt_rx_ack     = 1'b1;
        owt_rx_cmd     = f_cmd;
        owt_rx_data    = f_data;
        owt_rx_status  = f_status;
        cur_is_spi_req = f_spi;
    endtask

    task automatic drive_idle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #(DRIVE_DLY);
            owt_rx_ack     = 1'b0;
            owt_rx_status  = 1'b0;
            cur_is_spi_req = 1'b0;
        end
    endtask

    task automatic wait_reset_release(output logic ok);
        int cycles;
        cycles = 0;
        while ((rst_n !== 1'b1) && (cycles < RST_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        ok = (rst_n === 1'b1);
    endtask

    task automatic finish_test(string name);
        int errs;
        errs = err_count - test_err_base;
        test_count++;
        if (errs != 0) begin
            fail_count++;
        end
        $display("test %-10s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
        test_err_base = err_count;
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin : main
        logic rst_ok;
        owt_rx_ack     = 1'b0;
        owt_rx_cmd     = '0;
        owt_rx_data    = '0;
        owt_rx_status  = 1'b0;
        cur_is_spi_req = 1'b0;
        seed           = 54;
        err_count      = 0;
        check_count    = 0;
        test_err_base  = 0;
        test_count     = 0;
        fail_count     = 0;
        wait_reset_release(rst_ok);
        if (!rst_ok) begin
            $display("reset was not released within %0d cycles", RST_TIMEOUT);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            @(negedge clk);
            compare_value("o_reg_efuse_config..o_reg_status2",
                          {reg_efuse_config, reg_efuse_status, reg_status1, reg_status2}, 0);
            compare_value("o_reg_status3..o_reg_bist2",
                          {reg_status3, reg_status4, reg_bist1, reg_bist2}, 0);
            compare_value("o_reg_adc2_data/o_reg_adc1_data", {reg_adc2_data, reg_adc1_data}, 0);
            compare_value("o_hv_ang_reg_vld/o_hv_dgt_reg_vld/o_hv_ang_reg_data",
                          {hv_ang_reg_vld, hv_dgt_reg_vld, hv_ang_reg_data}, 0);
            finish_test("reset");

            for (int i = 0; i < 9; i++) begin
                drive_frame({1'b0, SHADOW_ADDR[i]}, rand_payload(), 1'b0, 1'b0);
                drive_idle(1);
            end
            drive_idle(2);
            finish_test("shadow");

            // status error, read flag, unmapped address
            drive_frame({1'b0, ADDR_STATUS1}, rand_payload(), 1'b1, 1'b0);
            drive_frame({1'b1, ADDR_BIST1}, rand_payload(), 1'b0, 1'b0);
            drive_frame({1'b0, 7'h10}, rand_payload(), 1'b0, 1'b0);
            drive_frame({1'b0, 7'h1E}, rand_payload(), 1'b0, 1'b0);
            drive_idle(2);
            finish_test("rejected");

            drive_frame({1'b0, ANG_START}, rand_payload(), 1'b0, 1'b1);
            drive_frame({1'b0, ANG_END}, rand_payload(), 1'b0, 1'b1);
            drive_frame({1'b1, 7'h2A}, rand_payload(), 1'b0, 1'b1);
            drive_idle(1);
            drive_frame({1'b0, 7'h30}, rand_payload(), 1'b0, 1'b0);
            drive_frame({1'b0, 7'h30}, rand_payload(), 1'b1, 1'b1);
            drive_idle(3);
            finish_test("analog");

            // back-to-back frames keep both digital pipeline stages busy
            drive_frame({1'b0, 7'h40}, rand_payload(), 1'b0, 1'b1);
            drive_frame({1'b0, 7'h41}, rand_payload(), 1'b0, 1'b1);
            drive_frame({1'b1, 7'h48}, rand_payload(), 1'b0, 1'b1);
            drive_frame({1'b0, 7'h50}, rand_payload(), 1'b0, 1'b1);
            drive_frame({1'b0, 7'h42}, rand_payload(), 1'b0, 1'b1);
            drive_frame({1'b0, 7'h4F}, rand_payload(), 1'b0, 1'b1);
            drive_frame({1'b0, 7'h48}, rand_payload(), 1'b0, 1'b0);
            drive_idle(3);
            finish_test("digital");

            $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                     test_count, fail_count, check_count, err_count);
            if (err_count == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
// testbench clock and active-low reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES  = 16,
    parameter int RST_DLY     = 2
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // release just after an edge as the stimulus does
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #(RST_DLY);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* source/lv_hv_shadow_top.sv */
// lv_hv_shadow_top, frame decoder, shadow bank and forwarder with plain ports
`timescale 1ns/1ps
`default_nettype none

module lv_hv_shadow_top import owt_pkg::*, hv_map_pkg::*; #(
    // analog register window on the high-voltage die
    parameter owt_addr_t ANG_START_ADDR = 7'h20,
    parameter owt_addr_t ANG_END_ADDR   = 7'h3F
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,

    // one-wire receiver
    input  wire logic                 i_owt_rx_ack,
    input  wire logic [OWT_CMD_W-1:0] i_owt_rx_cmd,
    input  wire owt_data_t            i_owt_rx_data,
    input  wire logic                 i_owt_rx_status,
    input  wire logic                 i_cur_is_spi_req,

    // shadow registers
    output hv_reg_t                   o_reg_efuse_config,
    output hv_reg_t                   o_reg_efuse_status,
    output hv_reg_t                   o_reg_status1,
    output hv_reg_t                   o_reg_status2,
    output hv_reg_t                   o_reg_status3,
    output hv_reg_t                   o_reg_status4,
    output hv_reg_t                   o_reg_bist1,
    output hv_reg_t                   o_reg_bist2,
    output hv_adc_t                   o_reg_adc1_data,
    output hv_adc_t                   o_reg_adc2_data,

    // forwarding
    output logic                      o_hv_ang_reg_vld,
    output hv_reg_t                   o_hv_ang_reg_data,
    output logic                      o_hv_dgt_reg_vld
);

    owt_frame_if u_frame_if ();

    // ======================================================================
    // frame decoder
    // ======================================================================

    owt_frame_decode #(
        .ANG_START_ADDR   (ANG_START_ADDR),
        .ANG_END_ADDR     (ANG_END_ADDR)
    ) u_decode (
        .i_owt_rx_ack     (i_owt_rx_ack),
        .i_owt_rx_cmd     (i_owt_rx_cmd),
        .i_owt_rx_data    (i_owt_rx_data),
        .i_owt_rx_status  (i_owt_rx_status),
        .i_cur_is_spi_req (i_cur_is_spi_req),
        .o_frame          (u_frame_if.decoder)
    );

    // ======================================================================
    // shadow bank
    // ======================================================================

    hv_shadow_bank u_bank (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_frame            (u_frame_if.bank),
        .o_reg_efuse_config (o_reg_efuse_config),
        .o_reg_efuse_status (o_reg_efuse_status),
        .o_reg_status1      (o_reg_status1),
        .o_reg_status2      (o_reg_status2),
        .o_reg_status3      (o_reg_status3),
        .o_reg_status4      (o_reg_status4),
        .o_reg_bist1        (o_reg_bist1),
        .o_reg_bist2        (o_reg_bist2),
        .o_reg_adc1_data    (o_reg_adc1_data),
        .o_reg_adc2_data    (o_reg_adc2_data)
    );

    // ======================================================================
    // forwarding controller
    // ======================================================================

    hv_fwd_ctrl u_fwd (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_frame           (u_frame_if.fwd),
        .o_hv_ang_reg_vld  (o_hv_ang_reg_vld),
        .o_hv_ang_reg_data (o_hv_ang_reg_data),
        .o_hv_dgt_reg_vld  (o_hv_dgt_reg_vld)
    );

endmodule

`default_nettype wire

/* source/hv_fwd_ctrl.sv */
// hv_fwd_ctrl, analog register forwarding and delayed digital hit flag
`timescale 1ns/1ps
`default_nettype none

module hv_fwd_ctrl import hv_map_pkg::*; (
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    owt_frame_if.fwd   i_frame,
    output logic       o_hv_ang_reg_vld,
    output hv_reg_t    o_hv_ang_reg_data,
    output logic       o_hv_dgt_reg_vld
);

    logic ang_fire;
    logic dgt_fire;
    logic dgt_vld_d1;

    assign ang_fire = i_frame.hit_vld & i_frame.ang_hit;
    assign dgt_fire = i_frame.hit_vld & i_frame.dgt_hit;

    // ======================================================================
    // analog window
    // ======================================================================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hv_ang_reg_vld <= 1'b0;
        end else begin
            o_hv_ang_reg_vld <= ang_fire;
        end
    end

    // holds the last forwarded byte between hits
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hv_ang_reg_data <= '0;
        end else if (ang_fire) begin
            o_hv_ang_reg_data <= i_frame.data[REG_DW-1:0];
        end
    end

    // ======================================================================
    // two-stage digital hit pipeline
    // ======================================================================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dgt_vld_d1       <= 1'b0;
            o_hv_dgt_reg_vld <= 1'b0;
        end else begin
            dgt_vld_d1       <= dgt_fire;
            o_hv_dgt_reg_vld <= dgt_vld_d1;
        end
    end

endmodule

`default_nettype wire

/* source/hv_shadow_bank.sv */
// hv_shadow_bank, local copy of the high-voltage die registers and adc data
`timescale 1ns/1ps
`default_nettype none

module hv_shadow_bank import owt_pkg::*, hv_map_pkg::*; (
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    owt_frame_if.bank  i_frame,
    output hv_reg_t    o_reg_efuse_config,
    output hv_reg_t    o_reg_efuse_status,
    output hv_reg_t    o_reg_status1,
    output hv_reg_t    o_reg_status2,
    output hv_reg_t    o_reg_status3,
    output hv_reg_t    o_reg_status4,
    output hv_reg_t    o_reg_bist1,
    output hv_reg_t    o_reg_bist2,
    output hv_adc_t    o_reg_adc1_data,
    output hv_adc_t    o_reg_adc2_data
);

    // ======================================================================
    // 8-bit shadow registers
    // ======================================================================

    localparam int SHD_NUM = 8;

    // slot 0 is efuse config, slot 7 is bist2
    localparam owt_addr_t [SHD_NUM-1:0] SHD_ADDR = {
        ADDR_BIST2,
        ADDR_BIST1,
        ADDR_STATUS4,
        ADDR_STATUS3,
        ADDR_STATUS2,
        ADDR_STATUS1,
        ADDR_EFUSE_STATUS,
        ADDR_EFUSE_CONFIG
    };

    genvar g;

    for (g = 0; g < SHD_NUM; g++) begin : g_shd
        hv_reg_t q;

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                q <= '0;
            end else if (i_frame.wr_vld && (i_frame.addr == SHD_ADDR[g])) begin
                q <= i_frame.data[REG_DW-1:0];
            end
        end
    end

    assign o_reg_efuse_config = g_shd[0].q;
    assign o_reg_efuse_status = g_shd[1].q;
    assign o_reg_status1      = g_shd[2].q;
    assign o_reg_status2      = g_shd[3].q;
    assign o_reg_status3      = g_shd[4].q;
    assign o_reg_status4      = g_shd[5].q;
    assign o_reg_bist1        = g_shd[6].q;
    assign o_reg_bist2        = g_shd[7].q;

    // ======================================================================
    // adc data register
    // ======================================================================

    logic             adc_wen;
    logic [2*ADC_DW-1:0] adc_q;

    assign adc_wen = i_frame.wr_vld && (i_frame.addr == ADDR_ADC_DATA);

    // one write carries both channels
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            adc_q <= '0;
        end else if (adc_wen) begin
            adc_q <= i_frame.data[2*ADC_DW-1:0];
        end
    end

    // channel 1 in the low half, channel 2 in the high half
    assign o_reg_adc1_data = adc_q[ADC_DW-1:0];
    assign o_reg_adc2_data = adc_q[2*ADC_DW-1:ADC_DW];

endmodule

`default_nettype wire

/* source/owt_frame_decode.sv */
// owt_frame_decode, frame qualification and address classification
`timescale 1ns/1ps
`default_nettype none

module owt_frame_decode import owt_pkg::*, hv_map_pkg::*; #(
    parameter owt_addr_t ANG_START_ADDR = 7'h20,
    parameter owt_addr_t ANG_END_ADDR   = 7'h3F
) (
    input  wire logic                 i_owt_rx_ack,
    input  wire logic [OWT_CMD_W-1:0] i_owt_rx_cmd,
    input  wire owt_data_t            i_owt_rx_data,
    input  wire logic                 i_owt_rx_status,
    input  wire logic                 i_cur_is_spi_req,
    owt_frame_if.decoder              o_frame
);

    logic      frame_ok;
    logic      cmd_rd;
    owt_addr_t cmd_addr;
    logic      dgt_match;

    // status high marks a corrupted frame
    assign frame_ok = i_owt_rx_ack & ~i_owt_rx_status;
    assign cmd_rd   = i_owt_rx_cmd[OWT_CMD_W-1];
    assign cmd_addr = i_owt_rx_cmd[OWT_ADDR_W-1:0];

    // ======================================================================
    // address classification
    // ======================================================================

    always_comb begin
        dgt_match = 1'b0;
        for (int i = 0; i < DGT_RD_REG_NUM; i++) begin
            if (cmd_addr == DGT_RD_REG_ADDR[i]) begin
                dgt_match = 1'b1;
            end
        end
    end

    assign o_frame.ang_hit = (cmd_addr >= ANG_START_ADDR) && (cmd_addr <= ANG_END_ADDR);
    assign o_frame.dgt_hit = dgt_match;

    // ======================================================================
    // qualified frame
    // ======================================================================

    assign o_frame.wr_vld  = frame_ok & ~cmd_rd;
    // forwarding ignores the read/write flag
    assign o_frame.hit_vld = frame_ok & i_cur_is_spi_req;
    assign o_frame.addr    = cmd_addr;
    assign o_frame.data    = i_owt_rx_data;

endmodule

`default_nettype wire

/* source/owt_frame_if.sv */
// owt_frame_if, qualified frame from the decoder to the shadow bank and forwarder
`timescale 1ns/1ps
`default_nettype none

interface owt_frame_if import owt_pkg::*; ();

    // all valid only in the acknowledge cycle
    logic      wr_vld;
    logic      hit_vld;
    owt_addr_t addr;
    owt_data_t data;
    logic      ang_hit;
    logic      dgt_hit;

    modport decoder (
        output wr_vld, hit_vld, addr, data, ang_hit, dgt_hit
    );

    modport bank (
        input wr_vld, addr, data
    );

    modport fwd (
        input hit_vld, ang_hit, dgt_hit, data
    );

endinterface

`default_nettype wire

/* source/hv_map_pkg.sv */
// high-voltage die register map, shadow register types, digital read list
`default_nettype none

package hv_map_pkg;

    import owt_pkg::*;

    // ======================================================================
    // register widths and types
    // ======================================================================

    localparam int REG_DW = 8;
    localparam int ADC_DW = 10;

    typedef logic [REG_DW-1:0] hv_reg_t;
    typedef logic [ADC_DW-1:0] hv_adc_t;

    // ======================================================================
    // shadowed register addresses
    // ======================================================================

    localparam owt_addr_t ADDR_EFUSE_CONFIG = 7'h06;
    localparam owt_addr_t ADDR_EFUSE_STATUS = 7'h07;
    localparam owt_addr_t ADDR_STATUS1      = 7'h08;
    localparam owt_addr_t ADDR_STATUS2      = 7'h0A;
    localparam owt_addr_t ADDR_STATUS3      = 7'h0C;
    localparam owt_addr_t ADDR_STATUS4      = 7'h0D;
    localparam owt_addr_t ADDR_BIST1        = 7'h14;
    localparam owt_addr_t ADDR_BIST2        = 7'h15;
    // both adc channels in one payload
    localparam owt_addr_t ADDR_ADC_DATA     = 7'h1F;

    // common readable digital registers with entry 0 at 0x40
    localparam int DGT_RD_REG_NUM = 4;
    localparam owt_addr_t [DGT_RD_REG_NUM-1:0] DGT_RD_REG_ADDR = {
        7'h50, 7'h48, 7'h41, 7'h40
    };

endpackage

`default_nettype wire

/* source/owt_pkg.sv */
// one-wire frame widths, address and payload types
`default_nettype none

package owt_pkg;

    // ======================================================================
    // frame format
    // ======================================================================

    // command is the read/write flag on top of the register address
    localparam int OWT_CMD_W  = 8;
    localparam int OWT_DATA_W = 20;
    localparam int OWT_ADDR_W = OWT_CMD_W - 1;

    // ======================================================================
    // frame field types
    // ======================================================================

    typedef logic [OWT_ADDR_W-1:0] owt_addr_t;
    typedef logic [OWT_DATA_W-1:0] owt_data_t;

endpackage

`default_nettype wire
